// File: la32_isa_pkg.sv
`default_nettype none

package la32_isa_pkg;

    typedef enum logic [6:0] {
        OPC_LU12I     = 7'h0a,
        OPC_PCADDU12I = 7'h0e
    } opc_1ri20_e;  // inst[31:25]

    typedef enum logic [9:0] {
        OPC_SLTI   = 10'h008,
        OPC_SLTUI  = 10'h009,
        OPC_ADDI_W = 10'h00a,
        OPC_ANDI   = 10'h00d,
        OPC_ORI    = 10'h00e,
        OPC_XORI   = 10'h00f,
        OPC_LD_W   = 10'h0a2,
        OPC_ST_W   = 10'h0a6
    } opc_2ri12_e;  // inst[31:22]

    typedef enum logic [16:0] {
        OPC_ADD_W = 17'h00020,
        OPC_SUB_W = 17'h00022,
        OPC_SLT   = 17'h00024,
        OPC_SLTU  = 17'h00025,
        OPC_AND   = 17'h00029,
        OPC_OR    = 17'h0002a,
        OPC_XOR   = 17'h0002b
    } opc_3r_e;  // inst[31:15]

    typedef enum logic [7:0] {
        ALU_NOP       = 8'h00,
        ALU_ADD       = 8'h01,
        ALU_SUB       = 8'h02,
        ALU_SLT       = 8'h03,
        ALU_SLTU      = 8'h04,
        ALU_AND       = 8'h05,
        ALU_OR        = 8'h06,
        ALU_XOR       = 8'h07,
        ALU_LU12I     = 8'h08,
        ALU_PCADDU12I = 8'h09,  // pc added in execute
        ALU_LD_W      = 8'h0a,
        ALU_ST_W      = 8'h0b
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP   = 3'd0,
        SEL_ARITH = 3'd1,
        SEL_LOGIC = 3'd2,
        SEL_MEM   = 3'd3
    } alu_sel_e;

    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_INE  = 7'h0d  // ecode for instruction not exist
    } exc_cause_e;

endpackage

`default_nettype wire

// File: la32_decode_pkg.sv
`default_nettype none

package la32_decode_pkg;

    // one format decoder's view of the word
    typedef struct packed {
        logic                   hit;
        la32_isa_pkg::alu_op_e  alu_op;
        la32_isa_pkg::alu_sel_e alu_sel;
        logic                   reg_write_en;
        logic [4:0]             reg_write_addr;  // rd
        logic                   reg1_read_en;
        logic [4:0]             reg1_read_addr;  // rj
        logic                   reg2_read_en;
        logic [4:0]             reg2_read_addr;  // rk, or rd for st.w
        logic [31:0]            imm;
    } dec_fields_t;

    typedef struct packed {
        logic [31:0]              pc;
        logic [31:0]              inst;
        dec_fields_t              fields;
        logic                     exception;
        la32_isa_pkg::exc_cause_e exc_cause;
    } id_result_t;

endpackage

`default_nettype wire

// File: id_1ri20.sv
`timescale 1ns/100ps
`default_nettype none

module id_1ri20 (
    input  logic [31:0]                  inst,
    output la32_decode_pkg::dec_fields_t dec
);

    logic [6:0]  opcode;
    logic [19:0] si20;
    logic [4:0]  rd;

    assign opcode = inst[31:25];
    assign si20   = inst[24:5];
    assign rd     = inst[4:0];

    always_comb begin
        dec = '0;
        case (opcode)
            la32_isa_pkg::OPC_LU12I: begin
                dec.hit    = 1'b1;
                dec.alu_op = la32_isa_pkg::ALU_LU12I;
            end
            la32_isa_pkg::OPC_PCADDU12I: begin
                dec.hit    = 1'b1;
                dec.alu_op = la32_isa_pkg::ALU_PCADDU12I;
            end
            default: begin
                dec.hit = 1'b0;
            end
        endcase

        if (dec.hit) begin
            dec.alu_sel        = la32_isa_pkg::SEL_ARITH;
            dec.reg_write_en   = 1'b1;
            dec.reg_write_addr = rd;
            dec.imm            = {si20, 12'b0};  // upper 20 bits
        end
    end

endmodule

`default_nettype wire

// File: id_2ri12.sv
`timescale 1ns/100ps
`default_nettype none

module id_2ri12 (
    input  logic [31:0]                  inst,
    output la32_decode_pkg::dec_fields_t dec
);

    logic [9:0]  opcode;
    logic [11:0] si12;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;

    assign opcode   = inst[31:22];
    assign si12     = inst[21:10];
    assign imm_sext = {{20{si12[11]}}, si12};
    assign imm_zext = {20'b0, si12};  // logical ops take ui12

    always_comb begin
        dec = '0;
        dec.hit = 1'b1;
        case (opcode)
            la32_isa_pkg::OPC_SLTI: begin
                dec.alu_op  = la32_isa_pkg::ALU_SLT;
                dec.alu_sel = la32_isa_pkg::SEL_ARITH;
                dec.imm     = imm_sext;
            end
            la32_isa_pkg::OPC_SLTUI: begin
                dec.alu_op  = la32_isa_pkg::ALU_SLTU;
                dec.alu_sel = la32_isa_pkg::SEL_ARITH;
                dec.imm     = imm_sext;  // still sign-extended
            end
            la32_isa_pkg::OPC_ADDI_W: begin
                dec.alu_op  = la32_isa_pkg::ALU_ADD;
                dec.alu_sel = la32_isa_pkg::SEL_ARITH;
                dec.imm     = imm_sext;
            end
            la32_isa_pkg::OPC_ANDI: begin
                dec.alu_op  = la32_isa_pkg::ALU_AND;
                dec.alu_sel = la32_isa_pkg::SEL_LOGIC;
                dec.imm     = imm_zext;
            end
            la32_isa_pkg::OPC_ORI: begin
                dec.alu_op  = la32_isa_pkg::ALU_OR;
                dec.alu_sel = la32_isa_pkg::SEL_LOGIC;
                dec.imm     = imm_zext;
            end
            la32_isa_pkg::OPC_XORI: begin
                dec.alu_op  = la32_isa_pkg::ALU_XOR;
                dec.alu_sel = la32_isa_pkg::SEL_LOGIC;
                dec.imm     = imm_zext;
            end
            la32_isa_pkg::OPC_LD_W: begin
                dec.alu_op  = la32_isa_pkg::ALU_LD_W;
                dec.alu_sel = la32_isa_pkg::SEL_MEM;
                dec.imm     = imm_sext;  // address offset
            end
            la32_isa_pkg::OPC_ST_W: begin
                dec.alu_op       = la32_isa_pkg::ALU_ST_W;
                dec.alu_sel      = la32_isa_pkg::SEL_MEM;
                dec.imm          = imm_sext;
                dec.reg2_read_en = 1'b1;  // store data comes from rd
            end
            default: begin
                dec.hit = 1'b0;
            end
        endcase

        if (dec.hit) begin
            dec.reg1_read_en   = 1'b1;
            dec.reg1_read_addr = inst[9:5];
            if (dec.reg2_read_en) begin
                dec.reg2_read_addr = inst[4:0];
            end
            if (dec.alu_op != la32_isa_pkg::ALU_ST_W) begin
                dec.reg_write_en   = 1'b1;
                dec.reg_write_addr = inst[4:0];
            end
        end
    end

    always_comb begin
        assert (!(dec.reg_write_en && dec.reg2_read_en))
            else $error("id_2ri12: rd both written and read");
    end

endmodule

`default_nettype wire

// File: id_3r.sv
`timescale 1ns/100ps
`default_nettype none

module id_3r (
    input  logic [31:0]                  inst,
    output la32_decode_pkg::dec_fields_t dec
);

    logic [16:0] opcode;
    logic [4:0]  rk;
    logic [4:0]  rj;
    logic [4:0]  rd;

    assign opcode = inst[31:15];
    assign rk     = inst[14:10];
    assign rj     = inst[9:5];
    assign rd     = inst[4:0];

    always_comb begin
        dec = '0;
        dec.hit     = 1'b1;
        dec.alu_sel = la32_isa_pkg::SEL_ARITH;
        case (opcode)
            la32_isa_pkg::OPC_ADD_W: begin
                dec.alu_op = la32_isa_pkg::ALU_ADD;
            end
            la32_isa_pkg::OPC_SUB_W: begin
                dec.alu_op = la32_isa_pkg::ALU_SUB;
            end
            la32_isa_pkg::OPC_SLT: begin
                dec.alu_op = la32_isa_pkg::ALU_SLT;
            end
            la32_isa_pkg::OPC_SLTU: begin
                dec.alu_op = la32_isa_pkg::ALU_SLTU;
            end
            la32_isa_pkg::OPC_AND: begin
                dec.alu_op  = la32_isa_pkg::ALU_AND;
                dec.alu_sel = la32_isa_pkg::SEL_LOGIC;
            end
            la32_isa_pkg::OPC_OR: begin
                dec.alu_op  = la32_isa_pkg::ALU_OR;
                dec.alu_sel = la32_isa_pkg::SEL_LOGIC;
            end
            la32_isa_pkg::OPC_XOR: begin
                dec.alu_op  = la32_isa_pkg::ALU_XOR;
                dec.alu_sel = la32_isa_pkg::SEL_LOGIC;
            end
            default: begin
                dec.hit     = 1'b0;
                dec.alu_sel = la32_isa_pkg::SEL_NOP;
            end
        endcase

        if (dec.hit) begin
            dec.reg1_read_en   = 1'b1;
            dec.reg1_read_addr = rj;
            dec.reg2_read_en   = 1'b1;
            dec.reg2_read_addr = rk;
            dec.reg_write_en   = 1'b1;
            dec.reg_write_addr = rd;  // imm stays zero
        end
    end

endmodule

`default_nettype wire

// File: id_stage.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        if_valid,
    input  logic [31:0]                 pc,
    input  logic [31:0]                 inst,
    input  logic                        stall,
    input  logic                        flush,
    output logic                        id_valid,
    output la32_decode_pkg::id_result_t id_out
);

    la32_decode_pkg::dec_fields_t dec_1ri20;
    la32_decode_pkg::dec_fields_t dec_2ri12;
    la32_decode_pkg::dec_fields_t dec_3r;
    la32_decode_pkg::id_result_t  id_next;

    id_1ri20 u_1ri20 (
        .inst (inst),
        .dec  (dec_1ri20)
    );

    id_2ri12 u_2ri12 (
        .inst (inst),
        .dec  (dec_2ri12)
    );

    id_3r u_3r (
        .inst (inst),
        .dec  (dec_3r)
    );

    // formats are disjoint, so order does not matter
    always_comb begin
        id_next           = '0;
        id_next.pc        = pc;
        id_next.inst      = inst;
        id_next.exc_cause = la32_isa_pkg::EXC_NONE;
        if (dec_1ri20.hit) begin
            id_next.fields = dec_1ri20;
        end else if (dec_2ri12.hit) begin
            id_next.fields = dec_2ri12;
        end else if (dec_3r.hit) begin
            id_next.fields = dec_3r;
        end else begin
            id_next.exception = 1'b1;  // fields stay zero
            id_next.exc_cause = la32_isa_pkg::EXC_INE;
        end
    end

    // bubbles carry an all-zero result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
            id_out   <= '0;
        end else if (flush) begin
            id_valid <= 1'b0;  // wins over stall
            id_out   <= '0;
        end else if (!stall) begin
            id_valid <= if_valid;
            if (if_valid) begin
                id_out <= id_next;
            end else begin
                id_out <= '0;
            end
        end
    end

    a_one_hit: assert property (@(posedge clk) disable iff (!rst_n)
        if_valid |-> $onehot0({dec_1ri20.hit, dec_2ri12.hit, dec_3r.hit}))
        else $error("id_stage: more than one format decoder hit");

    a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !id_valid)
        else $error("id_stage: id_valid set after flush");

    a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        stall && !flush |=> $stable(id_out) && $stable(id_valid))
        else $error("id_stage: output moved during stall");

endmodule

`default_nettype wire

// File: tb_id_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_id_stage;

    localparam int num_tests = 300;
    localparam int res_w     = $bits(la32_decode_pkg::id_result_t);

    logic        clk;
    logic        rst_n;
    logic        if_valid;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        stall;
    logic        flush;
    logic        id_valid;
    la32_decode_pkg::id_result_t id_out;

    integer      seed;
    integer      errors;
    logic        want_valid;
    logic        fresh;
    la32_decode_pkg::id_result_t cur_exp;
    la32_decode_pkg::id_result_t pending[$];

    id_stage u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_valid (if_valid),
        .pc       (pc),
        .inst     (inst),
        .stall    (stall),
        .flush    (flush),
        .id_valid (id_valid),
        .id_out   (id_out)
    );

    always #50 clk = ~clk;

    task automatic check(input string name, input logic [res_w-1:0] got,
                         input logic [res_w-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
            errors = errors + 1;
        end
    endtask

    // expected result rebuilt from the LoongArch32 encoding rules
    function automatic la32_decode_pkg::id_result_t expect_decode(input logic [31:0] pc_v,
                                                                  input logic [31:0] inst_v);
        la32_decode_pkg::id_result_t r;
        logic is_2ri;
        logic is_3r;
        logic [31:0] sext;
        r = '0;
        r.pc = pc_v;
        r.inst = inst_v;
        r.exc_cause = la32_isa_pkg::EXC_NONE;
        is_2ri = 1'b1;
        is_3r = 1'b1;
        sext = {{20{inst_v[21]}}, inst_v[21:10]};
        if (inst_v[31:25] == 7'h0a || inst_v[31:25] == 7'h0e) begin
            r.fields.hit = 1'b1;
            r.fields.alu_op = (inst_v[27]) ? la32_isa_pkg::ALU_PCADDU12I
                                           : la32_isa_pkg::ALU_LU12I;
            r.fields.alu_sel = la32_isa_pkg::SEL_ARITH;
            r.fields.reg_write_en = 1'b1;
            r.fields.reg_write_addr = inst_v[4:0];
            r.fields.imm = {inst_v[24:5], 12'h000};
            return r;
        end
        r.fields.imm = sext;
        r.fields.alu_sel = la32_isa_pkg::SEL_ARITH;
        case (inst_v[31:22])
            10'h008: r.fields.alu_op = la32_isa_pkg::ALU_SLT;
            10'h009: r.fields.alu_op = la32_isa_pkg::ALU_SLTU;
            10'h00a: r.fields.alu_op = la32_isa_pkg::ALU_ADD;
            10'h00d: r.fields.alu_op = la32_isa_pkg::ALU_AND;
            10'h00e: r.fields.alu_op = la32_isa_pkg::ALU_OR;
            10'h00f: r.fields.alu_op = la32_isa_pkg::ALU_XOR;
            10'h0a2: r.fields.alu_op = la32_isa_pkg::ALU_LD_W;
            10'h0a6: r.fields.alu_op = la32_isa_pkg::ALU_ST_W;
            default: is_2ri = 1'b0;
        endcase
        if (is_2ri) begin
            r.fields.hit = 1'b1;
            if (inst_v[31:22] == 10'h0a2 || inst_v[31:22] == 10'h0a6) begin
                r.fields.alu_sel = la32_isa_pkg::SEL_MEM;
            end else if (inst_v[31:22] >= 10'h00d) begin
                r.fields.alu_sel = la32_isa_pkg::SEL_LOGIC;
                r.fields.imm = {20'h00000, inst_v[21:10]};  // ui12
            end
            r.fields.reg1_read_en = 1'b1;
            r.fields.reg1_read_addr = inst_v[9:5];
            if (inst_v[31:22] == 10'h0a6) begin
                r.fields.reg2_read_en = 1'b1;
                r.fields.reg2_read_addr = inst_v[4:0];
            end else begin
                r.fields.reg_write_en = 1'b1;
                r.fields.reg_write_addr = inst_v[4:0];
            end
            return r;
        end
        r.fields.imm = '0;
        case (inst_v[31:15])
            17'h00020: r.fields.alu_op = la32_isa_pkg::ALU_ADD;
            17'h00022: r.fields.alu_op = la32_isa_pkg::ALU_SUB;
            17'h00024: r.fields.alu_op = la32_isa_pkg::ALU_SLT;
            17'h00025: r.fields.alu_op = la32_isa_pkg::ALU_SLTU;
            17'h00029: r.fields.alu_op = la32_isa_pkg::ALU_AND;
            17'h0002a: r.fields.alu_op = la32_isa_pkg::ALU_OR;
            17'h0002b: r.fields.alu_op = la32_isa_pkg::ALU_XOR;
            default: is_3r = 1'b0;
        endcase
        if (is_3r) begin
            r.fields.hit = 1'b1;
            if (inst_v[31:15] >= 17'h00029) begin
                r.fields.alu_sel = la32_isa_pkg::SEL_LOGIC;
            end
            r.fields.reg1_read_en = 1'b1;
            r.fields.reg1_read_addr = inst_v[9:5];
            r.fields.reg2_read_en = 1'b1;
            r.fields.reg2_read_addr = inst_v[14:10];
            r.fields.reg_write_en = 1'b1;
            r.fields.reg_write_addr = inst_v[4:0];
        end else begin
            r.fields = '0;  // no decoder claims it
            r.exception = 1'b1;
            r.exc_cause = la32_isa_pkg::EXC_INE;
        end
        return r;
    endfunction

    // builds one random word of the given kind
    function automatic logic [31:0] make_word(input int kind, input logic [31:0] rnd);
        logic [9:0]  ops_2ri[8];
        logic [16:0] ops_3r[7];
        ops_2ri = '{10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f, 10'h0a2, 10'h0a6};
        ops_3r = '{17'h00020, 17'h00022, 17'h00024, 17'h00025, 17'h00029, 17'h0002a,
                   17'h0002b};
        case (kind)
            0: return {(rnd[31] ? 7'h0e : 7'h0a), rnd[24:0]};
            1: return {ops_2ri[rnd[31:29]], rnd[21:0]};
            2: return {ops_3r[rnd[31:29] % 7], rnd[14:0]};
            default: return rnd | 32'h8000_0000;  // bit 31 is in no opcode
        endcase
    endfunction

    // reference model of the pipeline register, updated on each edge
    always @(posedge clk) begin
        fresh <= 1'b0;
        if (rst_n) begin
            if (flush) begin
                pending.delete();
                want_valid <= 1'b0;
            end else if (!stall) begin
                want_valid <= if_valid;
                fresh <= 1'b1;  // register loads this edge
                if (if_valid) begin
                    pending.push_back(expect_decode(pc, inst));
                end
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            check("id_valid", res_w'(id_valid), res_w'(want_valid));
            if (fresh && id_valid) begin
                if (pending.size() == 0) begin
                    $display("id_valid set with no expectation queued at %0t", $time);
                    errors = errors + 1;
                end else begin
                    cur_exp = pending.pop_front();
                end
            end
            if (want_valid) begin
                check("id_out", id_out, cur_exp);
            end else begin
                check("id_out", id_out, '0);
            end
        end
    end

    initial begin
        #((num_tests + 50) * 100);
        $display("timeout: run did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        clk = 1'b0;
        rst_n = 1'b0;
        if_valid = 1'b0;
        pc = '0;
        inst = '0;
        stall = 1'b0;
        flush = 1'b0;
        seed = 32'h9aa2;
        errors = 0;
        want_valid = 1'b0;
        fresh = 1'b0;
        cur_exp = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);  // idle, outputs stay zero
        for (int i = 0; i < num_tests; i++) begin
            @(posedge clk);
            rnd = $random(seed);
            if_valid <= (i % 9 != 8);
            pc <= {rnd[15:0], 16'h0} + 32'(i * 4);
            inst <= make_word(i % 4, $random(seed));
            stall <= (i >= num_tests / 3) && (rnd[19:18] == 2'b00);
            flush <= (i >= num_tests / 2) && (rnd[23:21] == 3'b000);
        end
        @(posedge clk);
        if_valid <= 1'b0;
        stall <= 1'b0;
        flush <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
la32_isa_pkg.sv
la32_decode_pkg.sv
id_1ri20.sv
id_2ri12.sv
id_3r.sv
id_stage.sv
tb_id_stage.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_id_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_id_stage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
